// File: cpu6502.f
cpu6502_pkg.sv
cpu6502_decode.sv
cpu6502_sequencer.sv
cpu6502_alu.sv
cpu6502_shift.sv
cpu6502_datapath.sv
cpu6502.sv
tb_cpu6502.sv

// File: cpu6502.sv
module cpu6502 (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               enable,        // Low stalls the whole core
    input  logic [cpu6502_pkg::data_width-1:0] data_in,
    output logic [cpu6502_pkg::addr_width-1:0] address,
    output logic [cpu6502_pkg::data_width-1:0] data_out,
    output logic                               write_enable,
    output logic                               sync,          // Opcode fetch cycle
    output logic [cpu6502_pkg::data_width-1:0] debug_opcode,
    output logic [cpu6502_pkg::addr_width-1:0] debug_pc,
    output logic [cpu6502_pkg::data_width-1:0] debug_a,
    output logic [cpu6502_pkg::data_width-1:0] debug_x,
    output logic [cpu6502_pkg::data_width-1:0] debug_y,
    output logic [cpu6502_pkg::data_width-1:0] debug_p
);

    logic [cpu6502_pkg::data_width-1:0] opcode, operand, store_data;
    logic                               commit, is_store, uses_alu, uses_shift;
    cpu6502_pkg::addr_mode_t            mode;
    cpu6502_pkg::alu_op_t               alu_op;
    cpu6502_pkg::shift_op_t             shift_op;
    cpu6502_pkg::dest_t                 dest;
    logic [1:0]                         flag_op, transfer_src, step;

    cpu6502_sequencer sequencer (
        .clock, .reset, .enable, .data_in, .mode, .is_store, .store_data,
        .opcode, .pc (debug_pc), .operand, .commit,
        .address, .data_out, .write_enable, .sync
    );

    cpu6502_decode decode (
        .opcode, .mode, .is_store, .alu_op, .shift_op, .dest,
        .uses_alu, .uses_shift, .flag_op, .transfer_src, .step
    );

    cpu6502_datapath datapath (
        .clock, .reset, .commit, .operand, .alu_op, .shift_op, .dest,
        .uses_alu, .uses_shift, .flag_op, .transfer_src, .step, .is_store, .opcode,
        .reg_a (debug_a), .reg_x (debug_x), .reg_y (debug_y), .status (debug_p), .store_data
    );

    assign debug_opcode = opcode;

endmodule

// File: cpu6502_alu.sv
module cpu6502_alu (
    input  logic [cpu6502_pkg::data_width-1:0] a_in,
    input  logic [cpu6502_pkg::data_width-1:0] b_in,
    input  logic                               c_in,
    input  cpu6502_pkg::alu_op_t               op,
    output logic [cpu6502_pkg::data_width-1:0] result,
    output logic                               c_out,
    output logic                               v_out
);

    logic                               subtract;
    logic                               carry;
    logic [cpu6502_pkg::data_width-1:0] addend;
    logic [cpu6502_pkg::data_width:0]   sum;     // Extra bit is the carry out

    assign subtract = (op == cpu6502_pkg::op_cmp) || (op == cpu6502_pkg::op_sbc);
    assign addend   = subtract ? ~b_in : b_in;                   // A + ~B + C for subtract
    assign carry    = (op == cpu6502_pkg::op_cmp) ? 1'b1 : c_in; // CMP ignores C
    assign sum      = {1'b0, a_in} + {1'b0, addend} + {8'd0, carry};

    always_comb begin
        case (op)
            cpu6502_pkg::op_ora: result = a_in | b_in;
            cpu6502_pkg::op_and: result = a_in & b_in;
            cpu6502_pkg::op_eor: result = a_in ^ b_in;
            cpu6502_pkg::op_lda: result = b_in;
            cpu6502_pkg::op_sta: result = a_in;      // Not committed
            default:             result = sum[7:0];  // ADC SBC CMP
        endcase
    end

    assign c_out = sum[8];
    // Signed overflow when both inputs agree in sign and the sum does not
    assign v_out = (a_in[7] ^ sum[7]) & (addend[7] ^ sum[7]);

endmodule

// File: cpu6502_datapath.sv
module cpu6502_datapath (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               commit,
    input  logic [cpu6502_pkg::data_width-1:0] operand,
    input  cpu6502_pkg::alu_op_t               alu_op,
    input  cpu6502_pkg::shift_op_t             shift_op,
    input  cpu6502_pkg::dest_t                 dest,
    input  logic                               uses_alu,
    input  logic                               uses_shift,
    input  logic [1:0]                         flag_op,
    input  logic [1:0]                         transfer_src,
    input  logic [1:0]                         step,
    input  logic                               is_store,
    input  logic [cpu6502_pkg::data_width-1:0] opcode,
    output logic [cpu6502_pkg::data_width-1:0] reg_a,
    output logic [cpu6502_pkg::data_width-1:0] reg_x,
    output logic [cpu6502_pkg::data_width-1:0] reg_y,
    output logic [cpu6502_pkg::data_width-1:0] status,
    output logic [cpu6502_pkg::data_width-1:0] store_data
);

    logic n_flag, v_flag, z_flag, c_flag;
    logic [cpu6502_pkg::data_width-1:0] alu_result, shift_result, source, result;
    logic alu_c, alu_v, shift_c;
    logic arith;     // ADC SBC CMP touch carry
    logic nz_update;

    cpu6502_alu alu (
        .a_in   (reg_a),
        .b_in   (operand),
        .c_in   (c_flag),
        .op     (alu_op),
        .result (alu_result),
        .c_out  (alu_c),
        .v_out  (alu_v)
    );

    cpu6502_shift shifter (
        .data_in  (reg_a),
        .c_in     (c_flag),
        .op       (shift_op),
        .data_out (shift_result),
        .c_out    (shift_c)
    );

    always_comb begin
        case (transfer_src)
            2'd1:    source = reg_a;
            2'd2:    source = reg_x;
            2'd3:    source = reg_y;
            default: source = operand;  // LDX LDY
        endcase
        if (uses_alu)        result = alu_result;
        else if (uses_shift) result = shift_result;
        else if (step == 2'd1) result = source + 8'd1;
        else if (step == 2'd2) result = source - 8'd1;
        else                   result = source;
    end

    assign arith = uses_alu && (alu_op == cpu6502_pkg::op_adc ||
                                alu_op == cpu6502_pkg::op_sbc ||
                                alu_op == cpu6502_pkg::op_cmp);
    assign nz_update = (dest != cpu6502_pkg::dest_none) ||
                       (uses_alu && alu_op == cpu6502_pkg::op_cmp);

    always_ff @(posedge clock) begin
        if (reset) begin
            reg_a  <= '0;
            reg_x  <= '0;
            reg_y  <= '0;
            n_flag <= 1'b0;
            v_flag <= 1'b0;
            z_flag <= 1'b0;
            c_flag <= 1'b0;
        end else if (commit) begin
            case (dest)
                cpu6502_pkg::dest_a: reg_a <= result;
                cpu6502_pkg::dest_x: reg_x <= result;
                cpu6502_pkg::dest_y: reg_y <= result;
                default: ;
            endcase
            if (nz_update) begin
                n_flag <= result[7];
                z_flag <= (result == '0);
            end
            if (arith) c_flag <= alu_c;
            if (arith && alu_op != cpu6502_pkg::op_cmp) v_flag <= alu_v;  // CMP leaves V
            if (uses_shift) c_flag <= shift_c;
            case (flag_op)
                2'd1: c_flag <= 1'b0;
                2'd2: c_flag <= 1'b1;
                2'd3: v_flag <= 1'b0;
                default: ;
            endcase
        end
    end

    always_comb begin
        status = 8'h20;                     // Bit 5 reads as one
        status[cpu6502_pkg::flag_n] = n_flag;
        status[cpu6502_pkg::flag_v] = v_flag;
        status[cpu6502_pkg::flag_z] = z_flag;
        status[cpu6502_pkg::flag_c] = c_flag;
    end

    // STY cc=00, STA cc=01, STX cc=10
    always_comb begin
        case (opcode[1:0])
            2'b00:   store_data = reg_y;
            2'b10:   store_data = reg_x;
            default: store_data = reg_a;
        endcase
        if (!is_store) store_data = '0;
    end

endmodule

// File: cpu6502_decode.sv
module cpu6502_decode (
    input  logic [cpu6502_pkg::data_width-1:0] opcode,
    output cpu6502_pkg::addr_mode_t            mode,
    output logic                               is_store,
    output cpu6502_pkg::alu_op_t               alu_op,
    output cpu6502_pkg::shift_op_t             shift_op,
    output cpu6502_pkg::dest_t                 dest,
    output logic                               uses_alu,
    output logic                               uses_shift,
    output logic [1:0]                         flag_op,       // 0 none, 1 CLC, 2 SEC, 3 CLV
    output logic [1:0]                         transfer_src,  // 0 operand, 1 A, 2 X, 3 Y
    output logic [1:0]                         step           // 0 none, 1 inc, 2 dec
);

    always_comb begin
        // Anything not matched below behaves as NOP
        mode         = cpu6502_pkg::implied;
        is_store     = 1'b0;
        dest         = cpu6502_pkg::dest_none;
        uses_alu     = 1'b0;
        uses_shift   = 1'b0;
        flag_op      = 2'd0;
        transfer_src = 2'd0;
        step         = 2'd0;
        alu_op       = cpu6502_pkg::alu_op_t'(opcode[7:5]);
        shift_op     = cpu6502_pkg::shift_op_t'(opcode[6:5]);

        casez (opcode)
            8'b???_001_01, 8'b???_010_01, 8'b???_011_01: begin // ALU group zp, imm, abs
                if (opcode != 8'h89) begin                       // No STA immediate
                    mode = (opcode[3:2] == 2'b10) ? cpu6502_pkg::immediate :
                           opcode[3] ? cpu6502_pkg::absolute : cpu6502_pkg::zeropage;
                    if (alu_op == cpu6502_pkg::op_sta) begin
                        is_store = 1'b1;
                    end else begin
                        uses_alu = 1'b1;
                        if (alu_op != cpu6502_pkg::op_cmp)
                            dest = cpu6502_pkg::dest_a;           // CMP keeps A
                    end
                end
            end
            8'b10?_001_?0, 8'b10?_011_?0, 8'b101_000_?0: begin // LDX LDY STX STY
                mode = (opcode[4:2] == 3'b000) ? cpu6502_pkg::immediate :
                       opcode[3] ? cpu6502_pkg::absolute : cpu6502_pkg::zeropage;
                if (opcode[5])
                    dest = opcode[1] ? cpu6502_pkg::dest_x : cpu6502_pkg::dest_y;
                else
                    is_store = 1'b1;
            end
            8'b0??_010_10: begin  // ASL ROL LSR ROR accumulator
                uses_shift = 1'b1;
                dest       = cpu6502_pkg::dest_a;
            end
            8'h4c: mode = cpu6502_pkg::jump;
            8'haa: begin dest = cpu6502_pkg::dest_x; transfer_src = 2'd1; end           // TAX
            8'ha8: begin dest = cpu6502_pkg::dest_y; transfer_src = 2'd1; end           // TAY
            8'h8a: begin dest = cpu6502_pkg::dest_a; transfer_src = 2'd2; end           // TXA
            8'h98: begin dest = cpu6502_pkg::dest_a; transfer_src = 2'd3; end           // TYA
            8'he8: begin dest = cpu6502_pkg::dest_x; transfer_src = 2'd2; step = 2'd1; end // INX
            8'hca: begin dest = cpu6502_pkg::dest_x; transfer_src = 2'd2; step = 2'd2; end // DEX
            8'hc8: begin dest = cpu6502_pkg::dest_y; transfer_src = 2'd3; step = 2'd1; end // INY
            8'h88: begin dest = cpu6502_pkg::dest_y; transfer_src = 2'd3; step = 2'd2; end // DEY
            8'h18: flag_op = 2'd1;  // CLC
            8'h38: flag_op = 2'd2;  // SEC
            8'hb8: flag_op = 2'd3;  // CLV
            default: ;
        endcase
    end

endmodule

// File: cpu6502_pkg.sv
package cpu6502_pkg;

    // Bus and register widths
    localparam int data_width = 8;
    localparam int addr_width = 16;

    // Low byte of the reset vector, high byte follows at the next address
    localparam logic [addr_width-1:0] reset_vector = 16'hfffc;

    // Flag positions in the status byte, bit 5 always reads as one
    localparam int flag_n = 7;
    localparam int flag_v = 6;
    localparam int flag_z = 1;
    localparam int flag_c = 0;

    // Kind of bus cycle
    typedef enum logic [2:0] {
        vector_low,      // Read FFFC
        vector_high,     // Read FFFD, load PC
        fetch_opcode,    // Sync cycle, commit of previous instruction
        fetch_operand,   // Byte after the opcode
        fetch_high,      // High address byte of absolute and JMP
        read_zeropage,
        read_absolute,
        write_memory     // Only cycle that drives write_enable
    } cpu_state_t;

    typedef enum logic [2:0] {
        implied,
        immediate,
        zeropage,
        absolute,
        jump             // JMP absolute
    } addr_mode_t;

    // Opcode bits 7 to 5 of the cc=01 group
    typedef enum logic [2:0] {
        op_ora, op_and, op_eor, op_adc, op_sta, op_lda, op_cmp, op_sbc
    } alu_op_t;

    // Opcode bits 6 to 5 of the accumulator shifts
    typedef enum logic [1:0] {
        op_asl, op_rol, op_lsr, op_ror
    } shift_op_t;

    typedef enum logic [1:0] {
        dest_none, dest_a, dest_x, dest_y
    } dest_t;

endpackage

// File: cpu6502_sequencer.sv
module cpu6502_sequencer (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               enable,
    input  logic [cpu6502_pkg::data_width-1:0] data_in,
    input  cpu6502_pkg::addr_mode_t            mode,
    input  logic                               is_store,
    input  logic [cpu6502_pkg::data_width-1:0] store_data,
    output logic [cpu6502_pkg::data_width-1:0] opcode,
    output logic [cpu6502_pkg::addr_width-1:0] pc,
    output logic [cpu6502_pkg::data_width-1:0] operand,
    output logic                               commit,
    output logic [cpu6502_pkg::addr_width-1:0] address,
    output logic [cpu6502_pkg::data_width-1:0] data_out,
    output logic                               write_enable,
    output logic                               sync
);

    cpu6502_pkg::cpu_state_t state;
    cpu6502_pkg::cpu_state_t state_next;
    logic [cpu6502_pkg::data_width-1:0] addr_low;  // Low address byte from fetch_operand
    logic [cpu6502_pkg::addr_width-1:0] pc_next;

    always_comb begin
        state_next = cpu6502_pkg::fetch_opcode;  // Most cycle kinds end the instruction
        pc_next    = pc;
        address    = pc;
        case (state)
            cpu6502_pkg::vector_low: begin
                address    = cpu6502_pkg::reset_vector;
                state_next = cpu6502_pkg::vector_high;
            end
            cpu6502_pkg::vector_high: begin
                address = cpu6502_pkg::reset_vector + 1'b1;
                pc_next = {data_in, operand};       // Low byte was registered last cycle
            end
            cpu6502_pkg::fetch_opcode: begin
                pc_next    = pc + 1'b1;
                state_next = cpu6502_pkg::fetch_operand;
            end
            cpu6502_pkg::fetch_operand: begin
                if (mode != cpu6502_pkg::implied)
                    pc_next = pc + 1'b1;            // Implied reads the next byte again
                if (mode == cpu6502_pkg::zeropage)
                    state_next = is_store ? cpu6502_pkg::write_memory
                                          : cpu6502_pkg::read_zeropage;
                else if (mode == cpu6502_pkg::absolute || mode == cpu6502_pkg::jump)
                    state_next = cpu6502_pkg::fetch_high;
            end
            cpu6502_pkg::fetch_high: begin
                if (mode == cpu6502_pkg::jump) begin
                    pc_next = {data_in, addr_low};
                end else begin
                    pc_next    = pc + 1'b1;
                    state_next = is_store ? cpu6502_pkg::write_memory
                                          : cpu6502_pkg::read_absolute;
                end
            end
            cpu6502_pkg::read_zeropage: address = {8'h00, operand};
            cpu6502_pkg::read_absolute: address = {operand, addr_low};
            cpu6502_pkg::write_memory:
                address = (mode == cpu6502_pkg::zeropage) ? {8'h00, operand}
                                                          : {operand, addr_low};
            default: state_next = cpu6502_pkg::vector_low;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= cpu6502_pkg::vector_low;
            pc     <= cpu6502_pkg::reset_vector;
            opcode <= 8'hea;                        // NOP, so the first commit is harmless
        end else if (enable) begin
            state <= state_next;
            pc    <= pc_next;
            if (state == cpu6502_pkg::fetch_opcode)
                opcode <= data_in;
        end
    end

    // Data input registered on every enabled cycle
    always_ff @(posedge clock) begin
        if (enable) begin
            operand <= data_in;
            if (state == cpu6502_pkg::fetch_operand)
                addr_low <= data_in;
        end
    end

    assign sync         = (state == cpu6502_pkg::fetch_opcode);
    assign commit       = sync && enable;   // Previous instruction retires here
    assign write_enable = (state == cpu6502_pkg::write_memory);
    assign data_out     = write_enable ? store_data : '0;

endmodule

// File: cpu6502_shift.sv
module cpu6502_shift (
    input  logic [cpu6502_pkg::data_width-1:0] data_in,
    input  logic                               c_in,
    input  cpu6502_pkg::shift_op_t             op,
    output logic [cpu6502_pkg::data_width-1:0] data_out,
    output logic                               c_out
);

    logic rotate;
    logic right;
    logic fill;   // Bit shifted into the vacated end

    assign rotate = (op == cpu6502_pkg::op_rol) || (op == cpu6502_pkg::op_ror);
    assign right  = (op == cpu6502_pkg::op_lsr) || (op == cpu6502_pkg::op_ror);
    assign fill   = rotate & c_in;

    always_comb begin
        if (right) begin
            data_out = {fill, data_in[7:1]};
            c_out    = data_in[0];
        end else begin
            data_out = {data_in[6:0], fill};
            c_out    = data_in[7];
        end
    end

endmodule

// File: tb_cpu6502.sv
module tb_cpu6502;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_period   = 20;
    localparam int prog_len       = 200;
    localparam int timeout_cycles = prog_len * 4 * 2 + 100;  // Worst case CPI, doubled for stalls

    logic        clock;
    logic        reset;
    logic        enable;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        write_enable;
    logic        sync;
    logic [7:0]  debug_opcode;
    logic [15:0] debug_pc;
    logic [7:0]  debug_a, debug_x, debug_y, debug_p;

    logic [7:0]  mem [0:65535];      // Memory seen by the core
    logic [7:0]  ref_mem [0:65535];  // Memory seen by the model
    logic [7:0]  op_table [0:51];

    // Model state
    logic [7:0]  m_a, m_x, m_y;
    logic        m_n, m_v, m_z, m_c;
    logic [15:0] model_pc, end_addr;
    int          exp_cycles;
    bit          store_pending;
    logic [15:0] exp_waddr;
    logic [7:0]  exp_wdata;

    // Register values due in the enabled cycle after a sync
    logic [7:0]  exp_a, exp_x, exp_y, exp_p, exp_opcode;
    logic [15:0] exp_pc;
    bit          reg_check_pending, at_end, done, seen_sync, started;
    int          enabled_cycles, cycles_since_sync;

    // Outputs of the previous cycle, for the stall check
    bit          have_prev, prev_en, prev_we;
    logic [15:0] prev_addr;
    logic [7:0]  prev_dout;

    int          checks, errors;

    cpu6502 uut (
        .clock, .reset, .enable, .data_in, .address, .data_out, .write_enable, .sync,
        .debug_opcode, .debug_pc, .debug_a, .debug_x, .debug_y, .debug_p
    );

    assign data_in = mem[address];  // Read answers in the same cycle

    always @(posedge clock) begin
        if (write_enable && enable)
            mem[address] <= data_out;
    end

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic compare_value(input string test, input logic [15:0] expected,
                                 input logic [15:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("[ERROR] %s expected %h actual %h at %0t", test, expected, actual, $time);
        end
    endtask

    task automatic require_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else begin
            errors++;
            $display("Error: %s at %0t", what, $time);
        end
    endtask

    // Table index 0-8 immediate, 9-20 zero page, 21-32 absolute, 33 JMP, rest one byte
    function automatic int instr_length(input int k);
        if (k < 21)
            return 2;
        else if (k < 34)
            return 3;
        else
            return 1;
    endfunction

    task automatic build_memory();
        int          kind [0:prog_len-1];
        logic [15:0] start [0:prog_len];
        logic [15:0] pc;
        int          i, j;
        op_table = '{8'ha9, 8'ha2, 8'ha0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9,
                     8'ha5, 8'ha6, 8'ha4, 8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5,
                     8'h85, 8'h86, 8'h84,
                     8'had, 8'hae, 8'hac, 8'h0d, 8'h2d, 8'h4d, 8'h6d, 8'hcd, 8'hed,
                     8'h8d, 8'h8e, 8'h8c,
                     8'h4c,
                     8'h0a, 8'h2a, 8'h4a, 8'h6a, 8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8,
                     8'hc8, 8'hca, 8'h88, 8'h18, 8'h38, 8'hb8, 8'hea, 8'h00, 8'h58};
        for (i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'ha5;   // Background fill
        for (i = 0; i < 256; i++) begin
            mem[i]           = $urandom;          // Zero-page data area
            mem[16'h3000 + i] = $urandom;         // Absolute data area
        end
        pc = 16'h0200;
        for (i = 0; i < prog_len; i++) begin
            kind[i]  = $urandom % 52;
            start[i] = pc;
            pc       = pc + instr_length(kind[i]);
        end
        start[prog_len] = pc;
        end_addr        = pc;
        for (i = 0; i < prog_len; i++) begin
            mem[start[i]] = op_table[kind[i]];
            if (kind[i] < 21) begin
                mem[start[i] + 1] = $urandom;     // Immediate value or zero-page address
            end else if (kind[i] < 33) begin
                mem[start[i] + 1] = $urandom;
                mem[start[i] + 2] = 8'h30;
            end else if (kind[i] == 33) begin
                j = i + 1 + ($urandom % 4);       // Forward only
                if (j > prog_len)
                    j = prog_len;
                mem[start[i] + 1] = start[j][7:0];
                mem[start[i] + 2] = start[j][15:8];
            end
        end
        mem[end_addr]     = 8'h4c;                // Final JMP to itself
        mem[end_addr + 1] = end_addr[7:0];
        mem[end_addr + 2] = end_addr[15:8];
        mem[16'hfffc] = 8'h00;
        mem[16'hfffd] = 8'h02;
        for (i = 0; i < 65536; i++)
            ref_mem[i] = mem[i];
    endtask

    task automatic update_nz(input logic [7:0] value);
        m_n = value[7];
        m_z = (value == 8'h00);
    endtask

    task automatic set_a(input logic [7:0] value);
        m_a = value;
        update_nz(value);
    endtask

    task automatic set_x(input logic [7:0] value);
        m_x = value;
        update_nz(value);
    endtask

    task automatic set_y(input logic [7:0] value);
        m_y = value;
        update_nz(value);
    endtask

    // Binary add or subtract on A
    task automatic add_binary(input logic [7:0] m, input bit subtract);
        int u;
        int s;
        if (subtract) begin
            u   = int'(m_a) - int'(m) - (m_c ? 0 : 1);
            s   = int'($signed(m_a)) - int'($signed(m)) - (m_c ? 0 : 1);
            m_c = (u >= 0);                       // No borrow
        end else begin
            u   = int'(m_a) + int'(m) + (m_c ? 1 : 0);
            s   = int'($signed(m_a)) + int'($signed(m)) + (m_c ? 1 : 0);
            m_c = (u > 255);
        end
        m_v = (s > 127) || (s < -128);
        m_a = u[7:0];
        update_nz(m_a);
    endtask

    task automatic run_instruction();
        logic [7:0]  op, m;
        logic        old_c;
        logic [15:0] ea, next_pc;
        bit          is_store;
        int          u;
        op         = ref_mem[model_pc];
        m          = 8'h00;
        ea         = 16'h0000;
        is_store   = 1'b0;
        exp_cycles = 2;
        next_pc    = model_pc + 16'd1;
        case (op)
            8'ha9, 8'ha2, 8'ha0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9: begin
                m       = ref_mem[model_pc + 16'd1];
                next_pc = model_pc + 16'd2;
            end
            8'ha5, 8'ha6, 8'ha4, 8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5,
            8'h85, 8'h86, 8'h84: begin
                ea         = {8'h00, ref_mem[model_pc + 16'd1]};
                m          = ref_mem[ea];
                exp_cycles = 3;
                next_pc    = model_pc + 16'd2;
            end
            8'had, 8'hae, 8'hac, 8'h0d, 8'h2d, 8'h4d, 8'h6d, 8'hcd, 8'hed,
            8'h8d, 8'h8e, 8'h8c: begin
                ea         = {ref_mem[model_pc + 16'd2], ref_mem[model_pc + 16'd1]};
                m          = ref_mem[ea];
                exp_cycles = 4;
                next_pc    = model_pc + 16'd3;
            end
            8'h4c: begin
                exp_cycles = 3;
                next_pc    = {ref_mem[model_pc + 16'd2], ref_mem[model_pc + 16'd1]};
            end
            default: ;                            // Implied, NOP and unsupported
        endcase
        old_c = m_c;
        case (op)
            8'ha9, 8'ha5, 8'had: set_a(m);                                 // LDA
            8'ha2, 8'ha6, 8'hae: set_x(m);                                 // LDX
            8'ha0, 8'ha4, 8'hac: set_y(m);                                 // LDY
            8'h09, 8'h05, 8'h0d: set_a(m_a | m);                           // ORA
            8'h29, 8'h25, 8'h2d: set_a(m_a & m);                           // AND
            8'h49, 8'h45, 8'h4d: set_a(m_a ^ m);                           // EOR
            8'h69, 8'h65, 8'h6d: add_binary(m, 1'b0);                      // ADC
            8'he9, 8'he5, 8'hed: add_binary(m, 1'b1);                      // SBC
            8'hc9, 8'hc5, 8'hcd: begin                                     // CMP
                u   = int'(m_a) - int'(m);
                m_c = (u >= 0);
                update_nz(u[7:0]);
            end
            8'h85, 8'h8d: begin
                is_store  = 1'b1;
                exp_wdata = m_a;
            end
            8'h86, 8'h8e: begin
                is_store  = 1'b1;
                exp_wdata = m_x;
            end
            8'h84, 8'h8c: begin
                is_store  = 1'b1;
                exp_wdata = m_y;
            end
            8'h0a: begin                                                   // ASL
                m_c = m_a[7];
                set_a({m_a[6:0], 1'b0});
            end
            8'h2a: begin
                m_c = m_a[7];
                set_a({m_a[6:0], old_c});
            end
            8'h4a: begin                                                   // LSR
                m_c = m_a[0];
                set_a({1'b0, m_a[7:1]});
            end
            8'h6a: begin
                m_c = m_a[0];
                set_a({old_c, m_a[7:1]});
            end
            8'haa: set_x(m_a);
            8'ha8: set_y(m_a);
            8'h8a: set_a(m_x);
            8'h98: set_a(m_y);
            8'he8: set_x(m_x + 8'd1);
            8'hc8: set_y(m_y + 8'd1);
            8'hca: set_x(m_x - 8'd1);
            8'h88: set_y(m_y - 8'd1);
            8'h18: m_c = 1'b0;
            8'h38: m_c = 1'b1;
            8'hb8: m_v = 1'b0;
            default: ;
        endcase
        if (is_store) begin
            store_pending = 1'b1;
            exp_waddr     = ea;
            ref_mem[ea]   = exp_wdata;
        end
        model_pc = next_pc;
    endtask

    // Called at the falling edge with the enable that the coming rising edge will see
    task automatic observe_cycle(input bit en);
        if (have_prev && !prev_en) begin          // Last cycle stalled, bus must hold
            compare_value("stall_address", prev_addr, address);
            compare_value("stall_write_enable", prev_we, write_enable);
            compare_value("stall_data_out", prev_dout, data_out);
        end
        have_prev = 1'b1;
        prev_en   = en;
        prev_addr = address;
        prev_we   = write_enable;
        prev_dout = data_out;
        if (sync && !seen_sync) begin
            seen_sync = 1'b1;
            compare_value("reset_vector_cycles", 16'd2, enabled_cycles);
            compare_value("reset_vector_address", 16'h0200, address);
        end
        if (!en)
            return;
        enabled_cycles++;
        if (reg_check_pending) begin
            require_true(!sync, "registers not observable before the next sync");
            compare_value("reg_a", exp_a, debug_a);
            compare_value("reg_x", exp_x, debug_x);
            compare_value("reg_y", exp_y, debug_y);
            compare_value("status", exp_p, debug_p);
            compare_value("debug_opcode", exp_opcode, debug_opcode);
            compare_value("debug_pc", exp_pc, debug_pc);
            reg_check_pending = 1'b0;
            if (at_end)
                done = 1'b1;
        end
        if (write_enable) begin
            require_true(store_pending, "write cycle with no store due");
            compare_value("store_address", exp_waddr, address);
            compare_value("store_data", exp_wdata, data_out);
            store_pending = 1'b0;
        end
        if (sync && seen_sync) begin
            if (started)
                compare_value("cycle_count", exp_cycles, cycles_since_sync);
            require_true(!store_pending, "store finished without a write cycle");
            compare_value("sync_address", model_pc, address);
            exp_a = m_a;                          // Previous instruction commits at this edge
            exp_x = m_x;
            exp_y = m_y;
            exp_p = {m_n, m_v, 1'b1, 3'b000, m_z, m_c};
            exp_opcode = ref_mem[model_pc];       // Opcode latched at this edge
            exp_pc     = model_pc + 16'd1;        // PC moves past the opcode
            reg_check_pending = 1'b1;
            if (model_pc == end_addr)
                at_end = 1'b1;
            else
                run_instruction();
            cycles_since_sync = 0;
            started           = 1'b1;
        end
        cycles_since_sync++;
    endtask

    initial begin
        int unsigned seed_value;
        bit          cycle_enable;
        seed_value = $urandom(32'h8d48_fc58);
        reset      = 1'b1;
        enable     = 1'b1;
        {m_a, m_x, m_y} = '0;
        {m_n, m_v, m_z, m_c} = '0;
        model_pc   = 16'h0200;
        build_memory();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        while (!done) begin
            cycle_enable = ($urandom % 4) != 0;   // Stall about a quarter of the cycles
            observe_cycle(cycle_enable);
            enable = cycle_enable;
            @(negedge clock);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        #(timeout_cycles * clock_period);
        $display("Watchdog: the program did not finish within %0d cycles", timeout_cycles);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
